// ==== periph_stim.txt ====
# op addr data exp name, op W write, R read, N wait, I nmi level, A nmi_acc, Q wdt_irq_acc
# E X L take addr as output (0 irq 1 reset 2 pnd 3 irq|reset) and data as cycles
R 0090 0000 6900 reset
W 0000 0001 0000 regs
R 0000 0000 0001 regs
W 0001 0010 0000 regs
R 0001 0000 0010 regs
W 0090 5a9a 0000 regs
R 0090 0000 6992 regs
W 0090 3300 0000 pw_bad
X 0001 0000 0001 pw_bad
R 0090 0000 6992 pw_bad
W 0090 5a1b 0000 interval
X 0000 0040 0001 interval
R 0001 0000 0011 interval
Q 0000 0000 0000 interval
E 0000 0001 0000 interval
R 0001 0000 0010 interval
W 0090 5a0b 0000 watchdog
X 0001 0040 0001 watchdog
R 0001 0000 0011 watchdog
W 0001 0000 0000 hold
W 0090 5a9b 0000 hold
L 0003 00c8 0000 hold
W 0000 0010 0000 nmi_rise
N 0000 0002 0000 nmi_rise
I 0000 0001 0000 nmi_rise
E 0002 0004 0001 nmi_rise
A 0000 0000 0000 nmi_rise
E 0002 0002 0000 nmi_rise
W 0090 5ac3 0000 nmi_fall
W 0001 0000 0000 nmi_fall
W 0000 0010 0000 nmi_fall
I 0000 0000 0000 nmi_fall
E 0002 0004 0001 nmi_fall

// ==== sources.f ====
+incdir+.
periph_pkg.sv
wdt_ctrl_reg.sv
wdt_counter.sv
sfr_regs.sv
periph_unit.sv
periph_unit_props.sv
tb_periph_unit.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP      = tb_periph_unit
FILELIST = sources.f

OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
LOG      = sim.log
SOURCES  = $(filter-out +incdir+%,$(shell cat $(FILELIST))) periph_params.svh

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== tb_periph_unit.sv ====
// ==============================
// Testbench for periph_unit, runs
// the operations in periph_stim.txt
// ==============================
`default_nettype none

module tb_periph_unit import periph_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  logic            mclk;
  logic            rst;
  per_bus_t        per_bus;
  logic            nmi;
  logic            nmi_acc;
  logic            wdt_irq_acc;
  per_data_t       per_dout;
  logic            wdt_irq;
  logic            wdt_reset;
  logic            nmi_pnd;

  int              fd;
  int              nf;                  // Fields found on a line
  int              limit_cycles = 100;  // Margin, file length added later
  int              n_checks = 0;
  logic            limit_ready = 1'b0;
  logic [7:0]      op;
  logic [15:0]     f_addr;              // Address, or output select
  logic [15:0]     f_data;              // Data, level or cycle count
  logic [15:0]     f_exp;
  logic [8*16-1:0] name;
  logic [8*96-1:0] line_buf;

  periph_unit dut (.*);

  initial mclk = 1'b0;
  always #20 mclk = ~mclk;  // 40 ns period

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_val(input logic [15:0] exp, input logic [15:0] act);
    n_checks = n_checks + 1;
    assert (act == exp) else
      abort_run($sformatf("ERROR %0s expected 0x%04h actual 0x%04h", name, exp, act));
  endtask

  // Inputs move 1 ns after the rising edge
  task automatic next_drive();
    @(posedge mclk);
    #1;
  endtask

  task automatic read_line();
    line_buf = '0;
    nf = $fgets(line_buf, fd);
    nf = $sscanf(line_buf, "%s %h %h %h %s", op, f_addr, f_data, f_exp, name);
    if (op == "#") nf = 0;  // Column notes
  endtask

  // 0 irq, 1 reset, 2 NMI pending, 3 irq or reset
  function automatic logic pick_out(input logic [15:0] sel);
    case (sel)
      16'd0:   pick_out = wdt_irq;
      16'd1:   pick_out = wdt_reset;
      16'd2:   pick_out = nmi_pnd;
      default: pick_out = wdt_irq | wdt_reset;
    endcase
  endfunction

  // ==============================
  // One stimulus operation
  // ==============================
  task automatic run_op();
    int   i;
    logic seen;
    case (op)
      "W", "R": begin
        next_drive();
        per_bus = '{addr: f_addr[13:0], din: f_data, we: (op == "W") ? 2'b11 : 2'b00, en: 1'b1};
        if (op == "R") begin
          @(negedge mclk);                  // Read data settled mid cycle
          check_val(f_exp, per_dout);
        end
        next_drive();
        per_bus = '0;
      end
      "N": repeat (f_data) @(posedge mclk);
      "I": begin
        next_drive();
        nmi = f_data[0];
      end
      "A", "Q": begin
        next_drive();
        nmi_acc     = (op == "A");
        wdt_irq_acc = (op == "Q");
        next_drive();
        nmi_acc     = 1'b0;
        wdt_irq_acc = 1'b0;
      end
      "E": begin                            // Level reached within a window
        seen = 1'b0;
        for (i = 0; i < int'(f_data) && !seen; i++) begin
          @(negedge mclk);
          seen = (pick_out(f_addr) == f_exp[0]);
        end
        check_val(f_exp, {15'd0, pick_out(f_addr)});
      end
      "X": begin                            // Low for data cycles, then high
        repeat (f_data) begin
          @(negedge mclk);
          check_val(16'h0000, {15'd0, pick_out(f_addr)});
        end
        @(negedge mclk);
        check_val(f_exp, {15'd0, pick_out(f_addr)});
      end
      "L": repeat (f_data) begin            // Level held for data cycles
        @(negedge mclk);
        check_val(f_exp, {15'd0, pick_out(f_addr)});
      end
      default: abort_run($sformatf("Unknown opcode %c in the stimulus file", op));
    endcase
  endtask

  initial begin
    rst         = 1'b1;
    per_bus     = '0;
    nmi         = 1'b0;
    nmi_acc     = 1'b0;
    wdt_irq_acc = 1'b0;
    fd = $fopen("periph_stim.txt", "r");
    if (fd == 0) abort_run("Cannot open the stimulus file periph_stim.txt");
    while (!$feof(fd)) begin                // First pass sizes the watchdog
      read_line();
      if (nf == 5) begin
        limit_cycles = limit_cycles + 1 + ((op inside {"N", "E", "X", "L"}) ? int'(f_data) : 0);
      end
    end
    $fclose(fd);
    limit_ready = 1'b1;
    repeat (3) @(posedge mclk);
    #1;
    rst = 1'b0;
    fd = $fopen("periph_stim.txt", "r");
    while (!$feof(fd)) begin
      read_line();
      if (nf == 5) run_op();
    end
    $fclose(fd);
    if (n_checks > 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      abort_run("No checks ran, the stimulus file held no operations");
    end
  end

  // Watchdog on the whole run
  initial begin
    wait (limit_ready);
    #(limit_cycles * 40);
    abort_run("Timeout, the stimulus did not finish in time");
  end

endmodule

`default_nettype wire

// ==== periph_unit_props.sv ====
// ==============================
// Bus and interrupt checks, bound
// into periph_unit
// ==============================
`default_nettype none

module periph_unit_props import periph_pkg::*; (
  input logic      mclk,
  input logic      rst,
  input per_bus_t  per_bus,
  input per_data_t per_dout,
  input wdt_cfg_t  wdt_cfg,
  input logic      nmiie,      // From the SFR block
  input logic      wdt_irq,
  input logic      wdt_reset,
  input logic      nmi_pnd
);

  timeunit 1ns;
  timeprecision 1ps;

  reset_single: assert property (@(posedge mclk) disable iff (rst) wdt_reset |=> !wdt_reset)
    else $error("wdt_reset stayed high for two cycles");

  irq_needs_tmsel: assert property (@(posedge mclk) disable iff (rst) wdt_irq |-> wdt_cfg.tmsel)
    else $error("wdt_irq high in watchdog mode");

  // Idle bus reads as zero
  dout_idle: assert property (@(posedge mclk) disable iff (rst) !per_bus.en |-> per_dout == '0)
    else $error("per_dout nonzero while en is low");

  pnd_needs_ie: assert property (@(posedge mclk) disable iff (rst) nmi_pnd |-> nmiie)
    else $error("nmi_pnd high with NMIIE clear");

endmodule

bind periph_unit periph_unit_props u_props (.*, .nmiie(u_sfr.nmiie));

`default_nettype wire

// ==== periph_unit.sv ====
// ==============================
// Peripheral slice top with the
// read data OR of all blocks
// ==============================
`default_nettype none

module periph_unit import periph_pkg::*; (
  input  logic      mclk,
  input  logic      rst,
  input  per_bus_t  per_bus,
  input  logic      nmi,
  input  logic      nmi_acc,
  input  logic      wdt_irq_acc,
  output per_data_t per_dout,
  output logic      wdt_irq,
  output logic      wdt_reset,
  output logic      nmi_pnd
);

  wdt_cfg_t  wdt_cfg;
  logic      cnt_clr;
  logic      wdt_expire;
  per_data_t wdt_rd_data;
  per_data_t sfr_rd_data;

  // ==============================
  // Watchdog timer
  // ==============================
  wdt_ctrl_reg u_wdt_ctrl (
    .mclk       (mclk),
    .rst        (rst),
    .per_bus    (per_bus),
    .wdt_expire (wdt_expire),   // From counter
    .wdt_cfg    (wdt_cfg),      // To counter and SFR
    .cnt_clr    (cnt_clr),
    .wdt_reset  (wdt_reset),
    .rd_data    (wdt_rd_data)
  );

  wdt_counter u_wdt_cnt (
    .mclk       (mclk),
    .rst        (rst),
    .wdt_cfg    (wdt_cfg),
    .cnt_clr    (cnt_clr),
    .wdt_expire (wdt_expire)
  );

  // Special function registers
  sfr_regs u_sfr (
    .mclk        (mclk),
    .rst         (rst),
    .per_bus     (per_bus),
    .wdt_cfg     (wdt_cfg),     // NMIES and TMSEL
    .wdt_expire  (wdt_expire),  // Sets WDTIFG
    .nmi         (nmi),
    .nmi_acc     (nmi_acc),
    .wdt_irq_acc (wdt_irq_acc),
    .rd_data     (sfr_rd_data),
    .wdt_irq     (wdt_irq),
    .nmi_pnd     (nmi_pnd)
  );

  // Undecoded blocks return zero
  assign per_dout = wdt_rd_data | sfr_rd_data;

endmodule

`default_nettype wire

// ==== sfr_regs.sv ====
// ==============================
// IE1 and IFG1 registers, NMI edge
// detect, interrupt outputs
// ==============================
`include "periph_params.svh"
`default_nettype none

module sfr_regs import periph_pkg::*; (
  input  logic      mclk,
  input  logic      rst,
  input  per_bus_t  per_bus,
  input  wdt_cfg_t  wdt_cfg,
  input  logic      wdt_expire,
  input  logic      nmi,          // Asynchronous pin
  input  logic      nmi_acc,      // NMI taken by the CPU
  input  logic      wdt_irq_acc,  // Watchdog interrupt taken
  output per_data_t rd_data,
  output logic      wdt_irq,
  output logic      nmi_pnd
);

  logic       rd;
  logic       ie1_wr;
  logic       ifg1_wr;
  logic       wdtie;
  logic       nmiie;
  logic       wdtifg;
  logic       nmiifg;
  logic       nmi_s1;
  logic       nmi_s2;
  logic       nmi_q;
  logic       nmi_edge;
  logic [7:0] ie1_byte;
  logic [7:0] ifg1_byte;

  // Byte registers live in the low lane
  assign rd      = per_bus.en && (per_bus.we == 2'b00);
  assign ie1_wr  = per_bus.en && per_bus.we[0] && (per_bus.addr == `PER_ADDR_IE1);
  assign ifg1_wr = per_bus.en && per_bus.we[0] && (per_bus.addr == `PER_ADDR_IFG1);

  // ==============================
  // NMI synchronizer and edge
  // ==============================
  always_ff @(posedge mclk) begin
    if (rst) begin
      nmi_s1 <= 1'b0;
      nmi_s2 <= 1'b0;
      nmi_q  <= 1'b0;
    end else begin
      nmi_s1 <= nmi;     // First stage
      nmi_s2 <= nmi_s1;  // Second stage
      nmi_q  <= nmi_s2;  // Previous level
    end
  end

  assign nmi_edge = wdt_cfg.nmies ? (nmi_q && !nmi_s2) : (nmi_s2 && !nmi_q);

  // Interrupt enables, NMIIE drops once the NMI is taken
  always_ff @(posedge mclk) begin
    if (rst) begin
      wdtie <= 1'b0;
      nmiie <= 1'b0;
    end else begin
      if (ie1_wr) wdtie <= per_bus.din[`SFR_BIT_WDT];
      if (nmi_acc) begin
        nmiie <= 1'b0;
      end else if (ie1_wr) begin
        nmiie <= per_bus.din[`SFR_BIT_NMI];
      end
    end
  end

  // Hardware set wins over software
  always_ff @(posedge mclk) begin
    if (rst) begin
      wdtifg <= 1'b0;
      nmiifg <= 1'b0;
    end else begin
      if (wdt_expire) begin
        wdtifg <= 1'b1;
      end else if (ifg1_wr) begin
        wdtifg <= per_bus.din[`SFR_BIT_WDT];
      end else if (wdt_irq_acc && wdt_cfg.tmsel) begin
        wdtifg <= 1'b0;  // Kept in watchdog mode as reset cause
      end
      if (nmi_edge) begin
        nmiifg <= 1'b1;
      end else if (ifg1_wr) begin
        nmiifg <= per_bus.din[`SFR_BIT_NMI];
      end
    end
  end

  // Read mux
  always_comb begin
    ie1_byte                  = 8'h00;
    ie1_byte[`SFR_BIT_WDT]    = wdtie;
    ie1_byte[`SFR_BIT_NMI]    = nmiie;
    ifg1_byte                 = 8'h00;
    ifg1_byte[`SFR_BIT_WDT]   = wdtifg;
    ifg1_byte[`SFR_BIT_NMI]   = nmiifg;
    rd_data                   = '0;
    if (rd && (per_bus.addr == `PER_ADDR_IE1)) begin
      rd_data = {8'h00, ie1_byte};
    end else if (rd && (per_bus.addr == `PER_ADDR_IFG1)) begin
      rd_data = {8'h00, ifg1_byte};
    end
  end

  assign wdt_irq = wdt_cfg.tmsel && wdtie && wdtifg;  // Interval mode only
  assign nmi_pnd = nmiie && nmiifg;

endmodule

`default_nettype wire

// ==== wdt_counter.sv ====
// ==============================
// Watchdog counter and expiry
// ==============================
`include "periph_params.svh"
`default_nettype none

module wdt_counter import periph_pkg::*; (
  input  logic     mclk,
  input  logic     rst,
  input  wdt_cfg_t wdt_cfg,
  input  logic     cnt_clr,     // Clear from a WDTCTL write
  output logic     wdt_expire   // One cycle strobe at the terminal count
);

  wdt_cnt_t cnt_q;
  wdt_cnt_t cnt_term;
  logic     cnt_hit;

  // Terminal value is interval length minus one
  always_comb begin
    case (wdt_cfg.is)
      2'd0:    cnt_term = wdt_cnt_t'(`WDT_IVAL_0 - 1);
      2'd1:    cnt_term = wdt_cnt_t'(`WDT_IVAL_1 - 1);
      2'd2:    cnt_term = wdt_cnt_t'(`WDT_IVAL_2 - 1);
      default: cnt_term = wdt_cnt_t'(`WDT_IVAL_3 - 1);
    endcase
  end

  assign cnt_hit    = (cnt_q >= cnt_term);                     // Also catches a shortened IS
  assign wdt_expire = cnt_hit && !wdt_cfg.hold && !cnt_clr;

  // Clear first, then hold, then count with wrap
  always_ff @(posedge mclk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (cnt_clr) begin
      cnt_q <= '0;
    end else if (!wdt_cfg.hold) begin
      if (cnt_hit) begin
        cnt_q <= '0;        // Wrap on expiry
      end else begin
        cnt_q <= cnt_q + wdt_cnt_t'(1);
      end
    end
  end

endmodule

`default_nettype wire

// ==== wdt_ctrl_reg.sv ====
// ==============================
// WDTCTL register with password
// check and watchdog reset pulse
// ==============================
`include "periph_params.svh"
`default_nettype none

module wdt_ctrl_reg import periph_pkg::*; (
  input  logic      mclk,
  input  logic      rst,
  input  per_bus_t  per_bus,
  input  logic      wdt_expire,   // Counter reached its terminal value
  output wdt_cfg_t  wdt_cfg,
  output logic      cnt_clr,      // Counter clear request
  output logic      wdt_reset,    // Registered reset pulse
  output per_data_t rd_data
);

  logic       sel;
  logic       wr;
  logic       rd;
  logic       pw_ok;
  logic       wr_ok;
  logic       wr_bad;
  logic [7:0] ctl_q;

  // ==============================
  // Address decode
  // ==============================
  assign sel    = per_bus.en && (per_bus.addr == `PER_ADDR_WDTCTL);
  assign wr     = sel && (per_bus.we != 2'b00);      // Any byte lane
  assign rd     = sel && (per_bus.we == 2'b00);
  assign pw_ok  = (per_bus.din[15:8] == `WDT_PW_KEY); // Password in upper byte
  assign wr_ok  = wr && pw_ok;
  assign wr_bad = wr && !pw_ok;                      // Violation

  // Lower byte storage, CNTCL never kept
  always_ff @(posedge mclk) begin
    if (rst) begin
      ctl_q <= 8'h00;
    end else if (wr_ok) begin
      ctl_q <= per_bus.din[7:0] & ~(8'h01 << `WDT_BIT_CNTCL);
    end
  end

  // Clear acts at the write edge itself
  assign cnt_clr = wr_ok && per_bus.din[`WDT_BIT_CNTCL];

  assign wdt_cfg = '{
    hold:  ctl_q[`WDT_BIT_HOLD],
    nmies: ctl_q[`WDT_BIT_NMIES],
    tmsel: ctl_q[`WDT_BIT_TMSEL],
    is:    ctl_q[1:0]             // IS field
  };

  // ==============================
  // Reset pulse
  // ==============================
  // Bad password or expiry in watchdog mode, never two cycles long
  always_ff @(posedge mclk) begin
    if (rst) begin
      wdt_reset <= 1'b0;
    end else begin
      wdt_reset <= !wdt_reset && (wr_bad || (wdt_expire && !wdt_cfg.tmsel));
    end
  end

  assign rd_data = rd ? {`WDT_RD_KEY, ctl_q} : per_data_t'(0); // Key above stored bits

endmodule

`default_nettype wire

// ==== periph_pkg.sv ====
// ==============================
// Shared types of the peripheral
// bus, watchdog and SFR blocks
// ==============================
`default_nettype none

package periph_pkg;

  // ==============================
  // Width types
  // ==============================
  typedef logic [13:0] per_addr_t;  // Peripheral word address
  typedef logic [15:0] per_data_t;  // Peripheral data word
  typedef logic [15:0] wdt_cnt_t;   // Watchdog count
  typedef logic [1:0]  wdt_is_t;    // Interval select

  // Peripheral bus from the CPU side, plain strobes
  typedef struct packed {
    per_addr_t   addr;  // Word address
    per_data_t   din;   // Write data
    logic [1:0]  we;    // Byte write enables, [0] is low byte
    logic        en;    // Access strobe
  } per_bus_t;

  // Watchdog settings decoded from WDTCTL
  typedef struct packed {
    logic    hold;   // Counter frozen
    logic    nmies;  // NMI edge, 1 is falling
    logic    tmsel;  // 1 interval mode, 0 watchdog mode
    wdt_is_t is;     // Interval select
  } wdt_cfg_t;

endpackage

`default_nettype wire

// ==== periph_params.svh ====
// ==============================
// Peripheral addresses, WDTCTL keys,
// register bit positions and intervals
// ==============================
`ifndef PERIPH_PARAMS_SVH
`define PERIPH_PARAMS_SVH

`default_nettype none

// ==============================
// Word addresses
// ==============================
`define PER_ADDR_IE1    14'h0000  // Interrupt enable 1
`define PER_ADDR_IFG1   14'h0001  // Interrupt flag 1
`define PER_ADDR_WDTCTL 14'h0090  // Watchdog control

// WDTCTL upper byte
`define WDT_PW_KEY 8'h5A  // Write password
`define WDT_RD_KEY 8'h69  // Value seen on read

// WDTCTL lower byte, IS sits in bits 1:0
`define WDT_BIT_HOLD  7  // Stop the counter
`define WDT_BIT_NMIES 6  // NMI falling edge select
`define WDT_BIT_TMSEL 4  // Interval mode
`define WDT_BIT_CNTCL 3  // Counter clear, self clearing

// IE1 and IFG1 share positions
`define SFR_BIT_WDT 0  // WDTIE / WDTIFG
`define SFR_BIT_NMI 4  // NMIIE / NMIIFG

// Interval lengths in mclk cycles
`define WDT_IVAL_0 32768
`define WDT_IVAL_1 8192
`define WDT_IVAL_2 512
`define WDT_IVAL_3 64

`default_nettype wire

`endif
